// ==== build.f ====
+incdir+sim
hw/xed_pkg.sv
hw/chip_crc_checker.sv
hw/weighted_parity_checker.sv
hw/parity_corrector.sv
hw/xed_decode_ctrl.sv
hw/xed_decoder.sv
sim/xed_asserts.sv
sim/xed_tb.sv

// ==== hw/chip_crc_checker.sv ====
// CRC-ATM over each chip, msb byte first with final inversion; fully combinational, deep logic
`default_nettype none

module chip_crc_checker
    import xed_pkg::*;
#(
    parameter crc_t CRC_POLY = 8'h07,
    parameter crc_t CRC_INIT = 8'hFF
) (
    input  wire xed_beat_t  beat_q,
    output      chip_mask_t crc_err
);

    localparam int BYTES = CHIP_W / 8;

    // one byte through the register, bitwise
    function automatic crc_t crc_update(crc_t crc, logic [7:0] data);
        crc_t c;
        c = crc ^ data;
        for (int b = 0; b < 8; b++) begin
            if (c[CRC_W-1]) begin
                c = (c << 1) ^ CRC_POLY;
            end else begin
                c = c << 1;
            end
        end
        return c;
    endfunction

    always_comb begin : crc_calc
        crc_t acc;
        for (int k = 0; k < NUM_CHIPS; k++) begin
            acc = CRC_INIT;
            for (int i = BYTES - 1; i >= 0; i--) begin
                acc = crc_update(acc, beat_q.chips[k][i*8 +: 8]);
            end
            crc_err[k] = (~acc != beat_q.crcs[k]);  // stored code is inverted
        end
    end

endmodule

`default_nettype wire

// ==== hw/parity_corrector.sv ====
// plain XOR syndrome and repair; can fix only one chip, chosen by the control module
`default_nettype none

module parity_corrector
    import xed_pkg::*;
(
    input  wire xed_beat_t                  beat_q,
    input  wire logic                       correct_en,
    input  wire chip_id_t                   correct_chip,
    output      logic                       syndrome_nonzero,
    output      chip_data_t [NUM_CHIPS-1:0] corrected
);

    parity_t syndrome;

    always_comb begin : synd
        parity_t acc;
        acc = beat_q.xor_parity;
        for (int k = 0; k < NUM_CHIPS; k++) begin
            acc = acc ^ beat_q.chips[k];
        end
        syndrome = acc;  // equals the error pattern of a single bad chip
    end

    assign syndrome_nonzero = |syndrome;

    // xor the syndrome back into the failed chip, others pass
    always_comb begin
        for (int k = 0; k < NUM_CHIPS; k++) begin
            if (correct_en && (correct_chip == chip_id_t'(k))) begin
                corrected[k] = beat_q.chips[k] ^ syndrome;
            end else begin
                corrected[k] = beat_q.chips[k];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/weighted_parity_checker.sv ====
// GF(256) weighted parity check, weight of chip k is 2^k; only flags a mismatch, never repairs
`default_nettype none

module weighted_parity_checker
    import xed_pkg::*;
#(
    parameter logic [7:0] GF_POLY = 8'h1D
) (
    input  wire xed_beat_t beat_q,
    output      logic      weighted_mismatch
);

    localparam int BYTES = CHIP_W / 8;

    parity_t wsum;
    parity_t wsyn;
    logic    grp0_bad;
    logic    grp1_bad;

    // multiply by x, reduce by the field polynomial
    function automatic logic [7:0] gf_xtime(logic [7:0] a);
        if (a[7]) begin
            return (a << 1) ^ GF_POLY;
        end
        return a << 1;
    endfunction

    // scale by 2^n through repeated xtime
    function automatic logic [7:0] gf_scale(logic [7:0] a, int n);
        logic [7:0] v;
        v = a;
        for (int j = 0; j < n; j++) begin
            v = gf_xtime(v);
        end
        return v;
    endfunction

    always_comb begin : weigh
        parity_t acc;
        acc = '0;
        for (int k = 0; k < NUM_CHIPS; k++) begin
            for (int i = 0; i < BYTES; i++) begin
                acc[i*8 +: 8] = acc[i*8 +: 8] ^ gf_scale(beat_q.chips[k][i*8 +: 8], k);
            end
        end
        wsum = acc;
    end

    assign wsyn     = wsum ^ beat_q.weighted_parity;
    assign grp0_bad = |wsyn[GROUP_W-1:0];
    assign grp1_bad = |wsyn[2*GROUP_W-1:GROUP_W];

    assign weighted_mismatch = grp0_bad || grp1_bad;

endmodule

`default_nettype wire

// ==== hw/xed_decode_ctrl.sv ====
// owns both pipeline stages; decode outputs read as clean/zero whenever their stage is idle
`default_nettype none

module xed_decode_ctrl
    import xed_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       in_valid,
    input  wire xed_beat_t                  beat,
    input  wire chip_mask_t                 crc_err,
    input  wire logic                       weighted_mismatch,
    input  wire logic                       syndrome_nonzero,
    input  wire chip_data_t [NUM_CHIPS-1:0] corrected,
    output      xed_beat_t                  beat_q,
    output      logic                       correct_en,
    output      chip_id_t                   correct_chip,
    output      logic                       out_valid,
    output      xed_result_t                result
);

    logic                       valid_q;       // stage-1 valid
    logic [CHIP_ID_W:0]         err_count;     // wide enough for all 8 chips
    chip_id_t                   err_idx;
    logic                       single_err;
    logic                       detected;
    logic                       correctable;
    xed_status_e                status_d;
    chip_id_t                   id_d;

    chip_data_t [NUM_CHIPS-1:0] chips_q;
    xed_status_e                status_q;
    logic                       detected_q;
    chip_id_t                   id_q;

    // stage 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            beat_q <= beat;
        end
    end

    // count CRC mismatches and encode the one-hot case
    always_comb begin
        err_count = '0;
        err_idx   = '0;
        for (int k = 0; k < NUM_CHIPS; k++) begin
            if (crc_err[k]) begin
                err_count = err_count + 1'b1;
                err_idx   = chip_id_t'(k);
            end
        end
    end

    assign single_err  = valid_q && (err_count == 1);
    assign detected    = valid_q && (syndrome_nonzero || weighted_mismatch);
    assign correctable = single_err && detected;
    assign id_d        = single_err ? err_idx : '0;

    assign correct_en   = correctable;
    assign correct_chip = id_d;

    always_comb begin
        if (correctable) begin
            status_d = XED_CORRECTED;
        end else if (detected) begin
            status_d = XED_UNCORRECTABLE;
        end else begin
            status_d = XED_CLEAN;
        end
    end

    // stage 2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            status_q   <= XED_CLEAN;
            detected_q <= 1'b0;
            id_q       <= '0;
        end else begin
            out_valid  <= valid_q;
            status_q   <= status_d;   // already clean when idle
            detected_q <= detected;
            id_q       <= id_d;
        end
    end

    always_ff @(posedge clk) begin
        chips_q <= valid_q ? corrected : '0;
    end

    assign result = '{
        chips:          chips_q,
        status:         status_q,
        error_detected: detected_q,
        error_chip_id:  id_q
    };

endmodule

`default_nettype wire

// ==== hw/xed_decoder.sv ====
// two-cycle XED decode pipeline; valid strobe only, no back-pressure, one beat per cycle max
`default_nettype none

module xed_decoder
    import xed_pkg::*;
#(
    parameter crc_t       CRC_POLY = 8'h07,
    parameter crc_t       CRC_INIT = 8'hFF,
    parameter logic [7:0] GF_POLY  = 8'h1D   // low byte of 0x11D
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        in_valid,
    input  wire xed_beat_t   beat,
    output      logic        out_valid,
    output      xed_result_t result
);

    xed_beat_t                  beat_q;
    chip_mask_t                 crc_err;
    logic                       weighted_mismatch;
    logic                       syndrome_nonzero;
    chip_data_t [NUM_CHIPS-1:0] corrected;
    logic                       correct_en;
    chip_id_t                   correct_chip;

    xed_decode_ctrl xed_decode_ctrl_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .in_valid          (in_valid),
        .beat              (beat),
        .crc_err           (crc_err),
        .weighted_mismatch (weighted_mismatch),
        .syndrome_nonzero  (syndrome_nonzero),
        .corrected         (corrected),
        .beat_q            (beat_q),
        .correct_en        (correct_en),
        .correct_chip      (correct_chip),
        .out_valid         (out_valid),
        .result            (result)
    );

    chip_crc_checker #(
        .CRC_POLY (CRC_POLY),
        .CRC_INIT (CRC_INIT)
    ) chip_crc_checker_i (
        .beat_q  (beat_q),
        .crc_err (crc_err)
    );

    weighted_parity_checker #(
        .GF_POLY (GF_POLY)
    ) weighted_parity_checker_i (
        .beat_q            (beat_q),
        .weighted_mismatch (weighted_mismatch)
    );

    // repair path, selected chip comes back from the control module
    parity_corrector parity_corrector_i (
        .beat_q           (beat_q),
        .correct_en       (correct_en),
        .correct_chip     (correct_chip),
        .syndrome_nonzero (syndrome_nonzero),
        .corrected        (corrected)
    );

endmodule

`default_nettype wire

// ==== hw/xed_pkg.sv ====
// shared widths and bundles for the XED decoder; geometry is fixed at 8 chips of 128 bits
`default_nettype none

package xed_pkg;

    localparam int NUM_CHIPS = 8;
    localparam int CHIP_W    = 128;  // data bits per chip
    localparam int GROUP_W   = 64;   // one parity half
    localparam int CRC_W     = 8;
    localparam int CHIP_ID_W = 3;

    typedef logic [CHIP_W-1:0]    chip_data_t;
    typedef logic [CRC_W-1:0]     crc_t;
    typedef logic [2*GROUP_W-1:0] parity_t;     // [GROUP_W-1:0] is group 0
    typedef logic [NUM_CHIPS-1:0] chip_mask_t;
    typedef logic [CHIP_ID_W-1:0] chip_id_t;

    // one input beat as delivered by the memory channel
    typedef struct packed {
        chip_data_t [NUM_CHIPS-1:0] chips;
        crc_t       [NUM_CHIPS-1:0] crcs;
        parity_t                    xor_parity;
        parity_t                    weighted_parity;  // chip k scaled by 2^k in GF(256)
    } xed_beat_t;

    typedef enum logic [1:0] {
        XED_CLEAN         = 2'd0,
        XED_CORRECTED     = 2'd1,
        XED_UNCORRECTABLE = 2'd2
    } xed_status_e;

    // decoded beat
    typedef struct packed {
        chip_data_t [NUM_CHIPS-1:0] chips;
        xed_status_e                status;
        logic                       error_detected;
        chip_id_t                   error_chip_id;
    } xed_result_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# builds and runs the XED decoder testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module xed_tb
out=$(./obj_dir/Vxed_tb)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
    exit 0
fi
exit 1

// ==== sim/xed_asserts.sv ====
// checks on the decode control module, bound to its module type; quiet while rst_n is low
`default_nettype none

module xed_asserts
    import xed_pkg::*;
(
    input wire logic        clk,
    input wire logic        rst_n,
    input wire logic        in_valid,
    input wire logic        out_valid,
    input wire logic        correct_en,
    input wire chip_id_t    correct_chip,
    input wire chip_mask_t  crc_err,
    input wire xed_result_t result
);
    timeunit 1ns;
    timeprecision 1ps;

    // stage-1 valid is in_valid one edge late, out_valid one more
    valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, 2))
        else $error("out_valid did not follow stage-1 valid");

    // repair only ever targets a lone CRC failure
    single_fail: assert property (@(posedge clk) disable iff (!rst_n)
        correct_en |-> (crc_err == (chip_mask_t'(1) << correct_chip)))
        else $error("correct_en high but crc_err is not the single bit of correct_chip");

    idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> (result.status == XED_CLEAN && !result.error_detected
                        && result.error_chip_id == '0))
        else $error("result fields not cleared while out_valid is low");

endmodule

bind xed_decode_ctrl xed_asserts xed_asserts_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .out_valid    (out_valid),
    .correct_en   (correct_en),
    .correct_chip (correct_chip),
    .crc_err      (crc_err),
    .result       (result)
);

`default_nettype wire

// ==== sim/xed_ref.svh ====
// reference model of the XED decode rules; polynomials fixed at the default parameters
`ifndef XED_REF_SVH
`define XED_REF_SVH

typedef chip_data_t [NUM_CHIPS-1:0] chip_set_t;

// CRC-ATM bit serial, msb first over the whole chip
function automatic crc_t crc_atm(chip_data_t d);
    crc_t c;
    logic fb;
    c = 8'hFF;
    for (int i = CHIP_W - 1; i >= 0; i--) begin
        fb = c[7] ^ d[i];
        c  = {c[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
    end
    return ~c;
endfunction

// carry-less product reduced by 0x11D
function automatic logic [7:0] gf_mul(logic [7:0] a, logic [7:0] b);
    logic [14:0] p;
    p = '0;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) p = p ^ (15'(a) << i);
    end
    for (int i = 14; i >= 8; i--) begin
        if (p[i]) p = p ^ (15'h11D << (i - 8));
    end
    return p[7:0];
endfunction

function automatic logic [7:0] gf_pow2(int k);
    logic [7:0] v;
    v = 8'h01;
    for (int j = 0; j < k; j++) begin
        v = gf_mul(v, 8'h02);
    end
    return v;
endfunction

// weighted sum of all chips, byte i of each chip lands in byte i
function automatic parity_t weighted_sum(chip_set_t chips);
    parity_t acc;
    acc = '0;
    for (int k = 0; k < NUM_CHIPS; k++) begin
        for (int i = 0; i < CHIP_W / 8; i++) begin
            acc[i*8 +: 8] = acc[i*8 +: 8] ^ gf_mul(chips[k][i*8 +: 8], gf_pow2(k));
        end
    end
    return acc;
endfunction

// fault-free beat with all codes filled in
function automatic xed_beat_t build_beat(chip_set_t chips);
    xed_beat_t b;
    b.chips           = chips;
    b.xor_parity      = '0;
    b.weighted_parity = weighted_sum(chips);
    for (int k = 0; k < NUM_CHIPS; k++) begin
        b.crcs[k]    = crc_atm(chips[k]);
        b.xor_parity = b.xor_parity ^ chips[k];
    end
    return b;
endfunction

function automatic xed_result_t expected_result(xed_beat_t b);
    xed_result_t r;
    parity_t     syn;
    int          bad;
    int          idx;
    logic        det;
    syn = b.xor_parity;
    bad = 0;
    idx = 0;
    for (int k = 0; k < NUM_CHIPS; k++) begin
        syn = syn ^ b.chips[k];
        if (crc_atm(b.chips[k]) != b.crcs[k]) begin
            bad++;
            idx = k;
        end
    end
    det              = (syn != '0) || (weighted_sum(b.chips) != b.weighted_parity);
    r.chips          = b.chips;
    r.error_detected = det;
    r.error_chip_id  = (bad == 1) ? chip_id_t'(idx) : '0;
    if (bad == 1 && det) begin
        r.status     = XED_CORRECTED;
        r.chips[idx] = b.chips[idx] ^ syn;  // syndrome is the error pattern
    end else if (det) begin
        r.status = XED_UNCORRECTABLE;
    end else begin
        r.status = XED_CLEAN;
    end
    return r;
endfunction

`endif

// ==== sim/xed_tb.sv ====
// directed then LFSR-random beats into the XED decoder at default parameters
`default_nettype none

module xed_tb
    import xed_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RANDOM_BEATS = 40;
    localparam int DRAIN_LIMIT  = 20;

    typedef struct {
        xed_result_t exp;
        int          due;   // cycle in which out_valid must show it
    } pending_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    xed_beat_t   beat;
    logic        out_valid;
    xed_result_t result;

    pending_t    pending[$];
    int          cycle;
    int          errors;
    int          checked;
    logic [31:0] lfsr_state;

    `include "xed_ref.svh"

    xed_decoder xed_decoder_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .beat      (beat),
        .out_valid (out_valid),
        .result    (result)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [127:0] take_bits(int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[126:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // kinds: 0 clean, 1 one chip, 2 two chips, 3 weighted parity, 4 plain parity, 5 one CRC
    function automatic xed_beat_t make_beat(int kind);
        chip_set_t  chips;
        xed_beat_t  b;
        int         k;
        int         k2;
        logic [7:0] e;
        chip_data_t flip;
        for (int i = 0; i < NUM_CHIPS; i++) begin
            chips[i] = chip_data_t'(take_bits(CHIP_W));
        end
        b    = build_beat(chips);
        k    = int'(take_bits(3));
        k2   = (k + 1 + int'(take_bits(3)) % 7) % NUM_CHIPS;
        e    = 8'(take_bits(8)) | 8'h01;  // nonzero error inside one byte
        flip = chip_data_t'(e) << (8 * int'(take_bits(4)));
        case (kind)
            1: b.chips[k] = b.chips[k] ^ flip;
            2: begin
                b.chips[k]  = b.chips[k] ^ flip;
                b.chips[k2] = b.chips[k2] ^ {flip[119:0], flip[127:120]};
            end
            3: b.weighted_parity = b.weighted_parity ^ flip;
            4: b.xor_parity      = b.xor_parity ^ flip;
            5: b.crcs[k]         = b.crcs[k] ^ e;
            default: ;
        endcase
        return b;
    endfunction

    task automatic check_status(xed_status_e got, xed_status_e exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: status %s, expected %s", $time, got.name(), exp.name());
        end
    endtask

    task automatic check_chip(chip_data_t got, chip_data_t exp, int k);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: chip %0d is %h, expected %h", $time, k, got, exp);
        end
    endtask

    task automatic check_id(chip_id_t got, chip_id_t exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: error_chip_id %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // drives one beat at edge+2ns and leaves time at the next edge+2ns
    task automatic send(xed_beat_t b);
        pending_t p;
        in_valid = 1'b1;
        beat     = b;
        p.exp    = expected_result(b);
        p.due    = cycle + 2;
        pending.push_back(p);
        @(posedge clk);
        #2;
    endtask

    task automatic idle(int n);
        in_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin : compare
        pending_t head;
        if (rst_n && out_valid) begin
            if (pending.size() == 0) begin
                errors++;
                $display("out_valid went high at %0t with no beat outstanding", $time);
            end else begin
                head = pending.pop_front();
                checked++;
                if (cycle != head.due) begin
                    errors++;
                    $display("error at %0t: result in cycle %0d, expected in cycle %0d",
                             $time, cycle, head.due);
                end
                check_status(result.status, head.exp.status);
                check_flag(result.error_detected, head.exp.error_detected, "error_detected");
                check_id(result.error_chip_id, head.exp.error_chip_id);
                for (int k = 0; k < NUM_CHIPS; k++) begin
                    check_chip(result.chips[k], head.exp.chips[k], k);
                end
            end
        end else if (rst_n && pending.size() != 0 && cycle >= pending[0].due) begin
            errors++;
            $display("no result by cycle %0d for a beat sent earlier", pending[0].due);
            void'(pending.pop_front());
        end
    end

    initial begin
        int waited;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        beat       = '0;
        cycle      = 0;
        errors     = 0;
        checked    = 0;
        lfsr_state = 32'd81308;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_flag(out_valid, 1'b0, "out_valid after reset");

        for (int kind = 0; kind < 6; kind++) begin
            send(make_beat(kind));
            idle(3);
        end
        for (int n = 0; n < RANDOM_BEATS; n++) begin
            send(make_beat(int'(take_bits(8)) % 6));  // back to back
        end
        idle(1);

        waited = 0;
        while (pending.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (pending.size() != 0) begin
            errors++;
            $display("timed out with %0d results still outstanding", pending.size());
        end
        $display("%0d results checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
